// File: sources.f
+incdir+verilog
verilog/lcd_pkg.sv
verilog/board_pkg.sv
verilog/cell_board.sv
verilog/rainbow_rand.sv
verilog/command_lut.sv
verilog/lcd_sequencer.sv
verilog/snake_lcd_top.sv
dv/snake_lcd_assert.sv
dv/tb_snake_lcd.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -j 0 --top-module tb_snake_lcd -f sources.f \
    -o sim_snake_lcd \
    && ./obj_dir/sim_snake_lcd | tee /dev/stderr | grep -x "ALL TESTS PASSED" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: dv/tb_snake_lcd.sv
`timescale 1ns/100ps
`include "snake_lcd_defines.svh"

module tb_snake_lcd;

    localparam int CLK_PERIOD  = 8;
    localparam int CELLS       = `BOARD_COLS * `BOARD_ROWS;
    localparam int CELL_PIX    = `CELL_PX * `CELL_PX;
    localparam int CELL_BYTES  = 11 + 2 * CELL_PIX;
    localparam int CELL_CYCLES = 2 * CELL_BYTES + 1;
    localparam int START_BYTES = 17 + 2 * `CLEAR_PIXELS;
    localparam int BATCHES     = 8;
    localparam int REST_WRITES = 8;
    localparam int BATCH_CYCLES   = (REST_WRITES + 2) * (CELL_CYCLES + CELLS);
    localparam int START_CYCLES   = 16 + 2 * START_BYTES + 2 * `INIT_PAUSE;
    localparam int TIMEOUT_CYCLES = 2 * (START_CYCLES + BATCHES * BATCH_CYCLES) + 1000;

    localparam lcd_pkg::rgb565_t BLANK = `COLOR_BLANK;

    logic                   clk, nrst, cell_we;
    board_pkg::cell_coord_t cell_x, cell_y;
    board_pkg::obj_code_t   cell_code;
    lcd_pkg::lcd_byte_t     lcd_d;
    logic                   lcd_dcx, lcd_wrx, busy, init_done;

    logic [8:0]       bytes_q [$];          // {dcx, data} of each bus write
    int               cyc_q [$];
    int               cycle = 0;
    int               cell_starts = 0;
    int               bytes_at_init = 0;
    logic             init_seen = 1'b0;
    logic [31:0]      seed;
    lcd_pkg::rgb565_t body_lfsr;
    logic [2:0]       board_code [CELLS];
    logic             pend [CELLS];
    int               checks, value_errors, other_errors;

    snake_lcd_top dut0 (
        .clk(clk), .nrst(nrst), .cell_we(cell_we), .cell_x(cell_x), .cell_y(cell_y),
        .cell_code(cell_code), .lcd_d(lcd_d), .lcd_dcx(lcd_dcx), .lcd_wrx(lcd_wrx),
        .busy(busy), .init_done(init_done)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // A byte is latched when the strobe rises after its low cycle
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (nrst && !lcd_wrx) begin
            bytes_q.push_back({lcd_dcx, lcd_d});
            cyc_q.push_back(cycle);
            if (init_seen && !lcd_dcx && (lcd_d == 8'h2A))
                cell_starts = cell_starts + 1;
        end
        if (nrst && init_done && !init_seen) begin
            init_seen     = 1'b1;
            bytes_at_init = bytes_q.size();
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic int rand_below(int n);
        return int'(lcg_next() >> 16) % n;
    endfunction

    function automatic lcd_pkg::rgb565_t lfsr_step(lcd_pkg::rgb565_t v);
        return v[0] ? ((v >> 1) ^ `RAINBOW_TAPS) : (v >> 1);
    endfunction

    function automatic lcd_pkg::rgb565_t pixel_color(logic [2:0] code, int pix,
                                                     lcd_pkg::rgb565_t body);
        case (code)
            board_pkg::OBJ_HEAD:   return `COLOR_HEAD;
            board_pkg::OBJ_BODY:   return body;
            board_pkg::OBJ_APPLE:  return (pix < `CELL_PX) ? `COLOR_LEAF : `COLOR_APPLE;
            board_pkg::OBJ_BORDER: return `COLOR_BORDER;
            default:               return `COLOR_BLANK;
        endcase
    endfunction

    task automatic check_val(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            value_errors++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        other_errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic pop_byte(output logic dcx, output logic [7:0] d, output int cyc);
        {dcx, d} = bytes_q.pop_front();
        cyc = cyc_q.pop_front();
    endtask

    task automatic expect_byte(input string name, input logic exp_dcx, input logic [7:0] exp_d);
        logic       dcx;
        logic [7:0] d;
        int         cyc;
        pop_byte(dcx, d, cyc);
        check_val(name, {exp_dcx, exp_d}, {dcx, d});
    endtask

    task automatic pop_data(input string name, output logic [7:0] d);
        logic dcx;
        int   cyc;
        pop_byte(dcx, d, cyc);
        if (!dcx)
            report_error({name, " was sent as a command instead of data"});
    endtask

    task automatic write_cell(input int x, input int y, input logic [2:0] code);
        @(negedge clk);
        cell_we   = 1'b1;
        cell_x    = board_pkg::cell_coord_t'(x);
        cell_y    = board_pkg::cell_coord_t'(y);
        cell_code = board_pkg::obj_code_t'(code);
        @(negedge clk);
        cell_we   = 1'b0;
    endtask

    task automatic check_startup();
        logic [8:0] exp_seq [17];
        int         cyc [17];
        int         t;
        logic       dcx;
        logic [7:0] d;
        exp_seq = '{9'h001, 9'h028, 9'h03A, 9'h155, 9'h011, 9'h029,
                    9'h02A, 9'h100, 9'h100, 9'h100, 9'h1F0,
                    9'h02B, 9'h100, 9'h100, 9'h101, 9'h140, 9'h02C};
        check_val("startup byte count at init_done", START_BYTES, bytes_at_init);
        if (bytes_q.size() != START_BYTES)
            report_error($sformatf("start-up stream has %0d bytes", bytes_q.size()));
        if (bytes_q.size() >= START_BYTES) begin
            for (int i = 0; i < 17; i++) begin
                pop_byte(dcx, d, cyc[i]);
                check_val($sformatf("startup command byte %0d", i), exp_seq[i], {dcx, d});
            end
            if (cyc[1] - cyc[0] < `INIT_PAUSE)
                report_error("pause after software reset is shorter than INIT_PAUSE");
            if (cyc[5] - cyc[4] < `INIT_PAUSE)
                report_error("pause after sleep out is shorter than INIT_PAUSE");
            for (int p = 0; p < `CLEAR_PIXELS; p++) begin
                pop_byte(dcx, d, t);
                check_val("startup clear pixel low byte", {1'b1, BLANK[7:0]}, {dcx, d});
                pop_byte(dcx, d, t);
                check_val("startup clear pixel high byte", {1'b1, BLANK[15:8]}, {dcx, d});
            end
        end
        bytes_q.delete();
        cyc_q.delete();
    endtask

    task automatic check_cell(input logic is_lead, input int lead_idx, input logic [2:0] lead_code);
        logic [7:0]       b0, b1, b2, b3, lo, hi;
        int               sc, sp, x, y, idx;
        logic [2:0]       code;
        lcd_pkg::rgb565_t exp_color;
        if (bytes_q.size() < CELL_BYTES) begin
            report_error("bus byte stream ends in the middle of a cell draw");
            bytes_q.delete();
            cyc_q.delete();
            return;
        end
        expect_byte("cell column command", 1'b0, 8'h2A);
        pop_data("column start high", b0);
        pop_data("column start low", b1);
        pop_data("column end high", b2);
        pop_data("column end low", b3);
        sc = {b0, b1};
        check_val("cell column window end", sc + `CELL_PX, {b2, b3});
        expect_byte("cell page command", 1'b0, 8'h2B);
        pop_data("page start high", b0);
        pop_data("page start low", b1);
        pop_data("page end high", b2);
        pop_data("page end low", b3);
        sp = {b0, b1};
        check_val("cell page window end", sp + `CELL_PX, {b2, b3});
        y = sc / `CELL_PX;                                 // Column window comes from the row
        x = sp / `CELL_PX;
        if ((sc % `CELL_PX != 0) || (sp % `CELL_PX != 0) || (y >= `BOARD_ROWS) ||
            (x >= `BOARD_COLS)) begin
            report_error("window start is not the corner of a board cell");
            bytes_q.delete();
            cyc_q.delete();
            return;
        end
        idx = y * `BOARD_COLS + x;
        if (is_lead) begin
            check_val("lead cell index", lead_idx, idx);
            code = lead_code;
        end else begin
            if (!pend[idx])
                report_error($sformatf("cell (%0d,%0d) drawn without a pending write", x, y));
            pend[idx] = 1'b0;
            code      = board_code[idx];
        end
        if (code == board_pkg::OBJ_BODY)
            body_lfsr = lfsr_step(body_lfsr);             // One step per body cell drawn
        expect_byte("cell memory write command", 1'b0, 8'h2C);
        for (int p = 0; p < CELL_PIX; p++) begin
            pop_data("pixel low byte", lo);
            pop_data("pixel high byte", hi);
            exp_color = pixel_color(code, p, body_lfsr);
            checks++;
            if ({hi, lo} != exp_color) begin
                value_errors++;
                $display("FAILED pixel %0d of cell (%0d,%0d) code %0d: expected %h, actual %h",
                         p, x, y, code, exp_color, {hi, lo});
            end
        end
    endtask

    task automatic run_batch(input int batch);
        int         lead_x, lead_y, starts, wait_cnt, expected, drawn, first_x, first_y, x, y;
        logic [2:0] lead_code, code;
        lead_x    = rand_below(`BOARD_COLS);
        lead_y    = rand_below(`BOARD_ROWS);
        lead_code = 3'(batch % 5);
        starts    = cell_starts;
        board_code[lead_y * `BOARD_COLS + lead_x] = lead_code;
        write_cell(lead_x, lead_y, lead_code);
        wait_cnt = 0;
        while ((cell_starts == starts) && (wait_cnt < 4 * CELLS)) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (cell_starts == starts)
            report_error("lead cell draw did not start");
        // Rest of the batch lands while the lead cell is still being drawn
        for (int i = 0; i <= REST_WRITES; i++) begin
            x    = (i == REST_WRITES) ? first_x : rand_below(`BOARD_COLS);
            y    = (i == 0) ? rand_below(`BOARD_ROWS) : rand_below(16);  // Rows 12 to 15 are off
            y    = (i == REST_WRITES) ? first_y : y;
            code = 3'(rand_below(5));
            if (i == 0) begin
                first_x = x;
                first_y = y;
            end
            if (y < `BOARD_ROWS) begin
                board_code[y * `BOARD_COLS + x] = code;
                pend[y * `BOARD_COLS + x]       = 1'b1;
            end
            write_cell(x, y, code);
        end
        expected = 1;
        foreach (pend[i])
            expected += pend[i];
        wait_cnt = 0;
        while (busy && (wait_cnt < BATCH_CYCLES)) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (busy)
            report_error($sformatf("busy still high after batch %0d", batch));
        check_cell(1'b1, lead_y * `BOARD_COLS + lead_x, lead_code);
        drawn = 1;
        while (bytes_q.size() > 0) begin
            check_cell(1'b0, 0, 3'd0);
            drawn++;
        end
        check_val($sformatf("cells drawn in batch %0d", batch), expected, drawn);
        foreach (pend[i]) begin
            if (pend[i])
                report_error($sformatf("cell %0d was written but never drawn", i));
            pend[i] = 1'b0;
        end
    endtask

    initial begin
        seed         = 32'h244f;
        body_lfsr    = `RAINBOW_SEED;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        foreach (pend[i]) begin
            pend[i]       = 1'b0;
            board_code[i] = 3'd0;
        end
        nrst      = 1'b0;
        cell_we   = 1'b0;
        cell_x    = '0;
        cell_y    = '0;
        cell_code = board_pkg::OBJ_BLANK;
        repeat (16) @(negedge clk);
        check_val("reset lcd_wrx", 1, lcd_wrx);
        check_val("reset lcd_dcx", 0, lcd_dcx);
        check_val("reset lcd_d", 0, lcd_d);
        check_val("reset busy", 1, busy);
        check_val("reset init_done", 0, init_done);
        nrst = 1'b1;
        while (!init_done)
            @(negedge clk);
        @(negedge clk);
        check_startup();
        for (int b = 0; b < BATCHES; b++)
            run_batch(b);
        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0))
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("ERROR: run did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors + 1);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: dv/snake_lcd_assert.sv
`timescale 1ns/100ps

module snake_lcd_assert (
    input logic                   clk,
    input logic                   nrst,
    input logic                   lcd_wrx,
    input lcd_pkg::lcd_byte_t     lcd_d,
    input logic                   lcd_dcx,
    input logic                   draw_req,
    input logic                   draw_take,
    input board_pkg::cell_coord_t draw_x,
    input board_pkg::cell_coord_t draw_y,
    input logic                   init_done
);

    wrx_single_low: assert property (@(posedge clk) disable iff (!nrst) !lcd_wrx |=> lcd_wrx)
        else $error("lcd_wrx low for two cycles in a row");

    // Panel latches on the rising strobe
    bus_stable: assert property (@(posedge clk) disable iff (!nrst)
        !lcd_wrx |=> ($stable(lcd_d) && $stable(lcd_dcx)))
        else $error("lcd_d or lcd_dcx changed while a byte was being written");

    // A request that is not taken stays on the same cell
    req_held: assert property (@(posedge clk) disable iff (!nrst)
        draw_req && !draw_take |=> draw_req && $stable(draw_x) && $stable(draw_y))
        else $error("draw request dropped or moved before it was taken");

    init_sticky: assert property (@(posedge clk) disable iff (!nrst) init_done |=> init_done)
        else $error("init_done fell");

endmodule

bind snake_lcd_top snake_lcd_assert u_assert (
    .clk(clk), .nrst(nrst), .lcd_wrx(lcd_wrx), .lcd_d(lcd_d), .lcd_dcx(lcd_dcx),
    .draw_req(draw_req), .draw_take(draw_take), .draw_x(draw_x), .draw_y(draw_y),
    .init_done(init_done)
);

// File: verilog/snake_lcd_top.sv
`timescale 1ns/100ps

module snake_lcd_top (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   cell_we,
    input  board_pkg::cell_coord_t cell_x,
    input  board_pkg::cell_coord_t cell_y,
    input  board_pkg::obj_code_t   cell_code,
    output lcd_pkg::lcd_byte_t     lcd_d,
    output logic                   lcd_dcx,
    output logic                   lcd_wrx,
    output logic                   busy,
    output logic                   init_done
);

    logic                   draw_req, draw_take, any_dirty, drawing;
    logic                   pause, cmd_finished, rainbow_step;
    board_pkg::cell_coord_t draw_x, draw_y;
    board_pkg::obj_code_t   draw_code;
    lcd_pkg::update_t       mode;
    lcd_pkg::rgb565_t       rainbow_color;

    cell_board u_board (
        .clk(clk), .nrst(nrst), .cell_we(cell_we), .cell_x(cell_x), .cell_y(cell_y),
        .cell_code(cell_code), .draw_take(draw_take), .draw_req(draw_req),
        .draw_x(draw_x), .draw_y(draw_y), .draw_code(draw_code), .any_dirty(any_dirty)
    );

    lcd_sequencer u_seq (
        .clk(clk), .nrst(nrst), .draw_req(draw_req), .draw_code(draw_code),
        .pause(pause), .cmd_finished(cmd_finished), .mode(mode), .draw_take(draw_take),
        .rainbow_step(rainbow_step), .init_done(init_done), .drawing(drawing)
    );

    command_lut u_lut (
        .clk(clk), .nrst(nrst), .mode(mode), .obj_code(draw_code), .x(draw_x), .y(draw_y),
        .rainbow_color(rainbow_color), .lcd_d(lcd_d), .lcd_dcx(lcd_dcx), .pause(pause),
        .cmd_finished(cmd_finished)
    );

    rainbow_rand u_rainbow (
        .clk(clk), .nrst(nrst), .enable(rainbow_step), .rainbow_color(rainbow_color)
    );

    // Strobe low in set cycles except while a start-up pause runs
    assign lcd_wrx = !((mode == lcd_pkg::SET) || ((mode == lcd_pkg::SET_I) && !pause));

    assign busy = !init_done || drawing || any_dirty;

endmodule

// File: verilog/lcd_sequencer.sv
`timescale 1ns/100ps

module lcd_sequencer (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 draw_req,
    input  board_pkg::obj_code_t draw_code,
    input  logic                 pause,
    input  logic                 cmd_finished,
    output lcd_pkg::update_t     mode,
    output logic                 draw_take,
    output logic                 rainbow_step,
    output logic                 init_done,
    output logic                 drawing
);

    typedef enum logic [1:0] {
        ST_INIT,
        ST_IDLE,
        ST_DRAW
    } seq_state_t;

    seq_state_t       state, next_state;
    lcd_pkg::update_t next_mode;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= ST_INIT;
            mode      <= lcd_pkg::IDLE;
            init_done <= 1'b0;
        end else begin
            state <= next_state;
            mode  <= next_mode;
            if ((state == ST_INIT) && (next_state == ST_IDLE))
                init_done <= 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        next_mode  = mode;
        case (state)
            ST_INIT: begin
                case (mode)
                    lcd_pkg::SET_I: begin
                        if (!pause)                  // Strobe stays high while waiting
                            next_mode = lcd_pkg::SEND_I;
                    end
                    lcd_pkg::SEND_I: begin
                        if (cmd_finished) begin
                            next_mode  = lcd_pkg::IDLE;
                            next_state = ST_IDLE;
                        end else begin
                            next_mode = lcd_pkg::SET_I;
                        end
                    end
                    default: next_mode = lcd_pkg::SET_I;
                endcase
            end
            ST_IDLE: begin
                if (draw_req) begin
                    next_mode  = lcd_pkg::SET;
                    next_state = ST_DRAW;
                end
            end
            ST_DRAW: begin
                if (mode != lcd_pkg::SEND) begin
                    next_mode = lcd_pkg::SEND;
                end else if (cmd_finished) begin
                    next_mode  = lcd_pkg::IDLE;
                    next_state = ST_IDLE;
                end else begin
                    next_mode = lcd_pkg::SET;
                end
            end
            default: begin
                next_mode  = lcd_pkg::IDLE;
                next_state = ST_INIT;
            end
        endcase
    end

    assign draw_take    = (state == ST_IDLE) && draw_req;
    assign rainbow_step = draw_take && (draw_code == board_pkg::OBJ_BODY);  // One step per body cell
    assign drawing      = (state == ST_DRAW);

endmodule

// File: verilog/command_lut.sv
`timescale 1ns/100ps
`include "snake_lcd_defines.svh"

module command_lut (
    input  logic                   clk,
    input  logic                   nrst,
    input  lcd_pkg::update_t       mode,
    input  board_pkg::obj_code_t   obj_code,
    input  board_pkg::cell_coord_t x,
    input  board_pkg::cell_coord_t y,
    input  lcd_pkg::rgb565_t       rainbow_color,
    output lcd_pkg::lcd_byte_t     lcd_d,
    output logic                   lcd_dcx,
    output logic                   pause,
    output logic                   cmd_finished
);

    localparam lcd_pkg::cmd_idx_t I_SWRESET = 5'd1;
    localparam lcd_pkg::cmd_idx_t I_SLPOUT  = 5'd5;
    localparam lcd_pkg::cmd_idx_t I_RAMWR   = 5'd17;
    localparam lcd_pkg::cmd_idx_t I_PIX_LO  = 5'd18;
    localparam lcd_pkg::cmd_idx_t I_PIX_HI  = 5'd19;
    localparam lcd_pkg::cmd_idx_t C_RAMWR   = 5'd11;
    localparam lcd_pkg::cmd_idx_t C_PIX_LO  = 5'd12;
    localparam lcd_pkg::cmd_idx_t C_PIX_HI  = 5'd13;

    localparam lcd_pkg::pix_count_t PAUSE_LEN   = lcd_pkg::pix_count_t'(`INIT_PAUSE);
    localparam lcd_pkg::pix_count_t CLEAR_LEN   = lcd_pkg::pix_count_t'(`CLEAR_PIXELS);
    localparam lcd_pkg::pix_count_t CELL_EDGE   = lcd_pkg::pix_count_t'(`CELL_PX);
    localparam lcd_pkg::pix_count_t CELL_PIXELS = lcd_pkg::pix_count_t'(`CELL_PX * `CELL_PX);

    lcd_pkg::cmd_idx_t      step, next_step, out_step;
    lcd_pkg::pix_count_t    count, next_count, out_count;
    board_pkg::obj_code_t   cur_code;
    board_pkg::cell_coord_t cur_x, cur_y;
    lcd_pkg::rgb565_t       cell_color, pix_color;
    logic [15:0]            sc, ec, sp, ep;
    logic                   in_init, in_cell, set_phase;

    assign in_init   = (mode == lcd_pkg::SET_I) || (mode == lcd_pkg::SEND_I);
    assign in_cell   = (mode == lcd_pkg::SET) || (mode == lcd_pkg::SEND);
    assign set_phase = (mode == lcd_pkg::SET_I) || (mode == lcd_pkg::SET);

    // Board outputs are valid in the take cycle, which is always IDLE
    always_ff @(posedge clk) begin
        if (mode == lcd_pkg::IDLE) begin
            cur_code <= obj_code;
            cur_x    <= x;
            cur_y    <= y;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            step  <= '0;
            count <= '0;
        end else begin
            step  <= next_step;
            count <= next_count;
        end
    end

    assign cmd_finished =
        ((mode == lcd_pkg::SEND_I) && (step == I_PIX_HI) && (count == CLEAR_LEN)) ||
        ((mode == lcd_pkg::SEND) && (step == C_PIX_HI) && (count == CELL_PIXELS));

    always_comb begin
        next_step  = step;
        next_count = count;
        pause      = 1'b0;
        case (mode)
            lcd_pkg::SET_I: begin
                case (step)
                    I_SWRESET, I_SLPOUT: begin
                        if (count < PAUSE_LEN) begin
                            pause      = 1'b1;
                            next_count = count + 1'b1;
                        end else begin
                            next_count = '0;
                            next_step  = step + 1'b1;
                        end
                    end
                    I_RAMWR, I_PIX_HI: begin
                        next_step  = I_PIX_LO;
                        next_count = count + 1'b1;       // Counts pixels from one
                    end
                    I_PIX_LO: next_step = I_PIX_HI;
                    default:  next_step = step + 1'b1;
                endcase
            end
            lcd_pkg::SET: begin
                case (step)
                    C_RAMWR, C_PIX_HI: begin
                        next_step  = C_PIX_LO;
                        next_count = count + 1'b1;
                    end
                    C_PIX_LO: next_step = C_PIX_HI;
                    default:  next_step = step + 1'b1;
                endcase
            end
            lcd_pkg::SEND_I, lcd_pkg::SEND: begin
                if (cmd_finished) begin
                    next_step  = '0;
                    next_count = '0;
                end
            end
            default: begin
            end
        endcase
    end

    // Byte of the step being entered, held through the send cycle
    assign out_step  = set_phase ? next_step : step;
    assign out_count = set_phase ? next_count : count;

    assign sc = 16'(cur_y) * 16'(`CELL_PX);
    assign ec = sc + 16'(`CELL_PX);
    assign sp = 16'(cur_x) * 16'(`CELL_PX);
    assign ep = sp + 16'(`CELL_PX);

    always_comb begin
        case (cur_code)
            board_pkg::OBJ_HEAD:   cell_color = `COLOR_HEAD;
            board_pkg::OBJ_BODY:   cell_color = rainbow_color;
            board_pkg::OBJ_APPLE:  cell_color = (out_count <= CELL_EDGE) ? `COLOR_LEAF : `COLOR_APPLE;
            board_pkg::OBJ_BORDER: cell_color = `COLOR_BORDER;
            default:               cell_color = `COLOR_BLANK;
        endcase
    end

    assign pix_color = in_init ? `COLOR_BLANK : cell_color;

    always_comb begin
        lcd_d   = '0;
        lcd_dcx = 1'b0;
        if (in_init) begin
            lcd_dcx = out_step inside {5'd4, [5'd8:5'd11], [5'd13:5'd16], I_PIX_LO, I_PIX_HI};
            case (out_step)
                I_SWRESET: lcd_d = 8'h01;
                5'd2:      lcd_d = 8'h28;           // Display off
                5'd3:      lcd_d = 8'h3A;           // Pixel format
                5'd4:      lcd_d = 8'h55;           // 16 bits per pixel
                I_SLPOUT:  lcd_d = 8'h11;
                5'd6:      lcd_d = 8'h29;           // Display on
                5'd7:      lcd_d = 8'h2A;
                5'd11:     lcd_d = 8'hF0;
                5'd12:     lcd_d = 8'h2B;
                5'd15:     lcd_d = 8'h01;
                5'd16:     lcd_d = 8'h40;
                I_RAMWR:   lcd_d = 8'h2C;
                I_PIX_LO:  lcd_d = pix_color[7:0];
                I_PIX_HI:  lcd_d = pix_color[15:8];
                default:   lcd_d = 8'h00;
            endcase
        end else if (in_cell) begin
            lcd_dcx = out_step inside {[5'd2:5'd5], [5'd7:5'd10], C_PIX_LO, C_PIX_HI};
            case (out_step)
                5'd1:     lcd_d = 8'h2A;            // Column window from y
                5'd2:     lcd_d = sc[15:8];
                5'd3:     lcd_d = sc[7:0];
                5'd4:     lcd_d = ec[15:8];
                5'd5:     lcd_d = ec[7:0];
                5'd6:     lcd_d = 8'h2B;            // Page window from x
                5'd7:     lcd_d = sp[15:8];
                5'd8:     lcd_d = sp[7:0];
                5'd9:     lcd_d = ep[15:8];
                5'd10:    lcd_d = ep[7:0];
                C_RAMWR:  lcd_d = 8'h2C;
                C_PIX_LO: lcd_d = pix_color[7:0];
                C_PIX_HI: lcd_d = pix_color[15:8];
                default:  lcd_d = 8'h00;
            endcase
        end
    end

endmodule

// File: verilog/rainbow_rand.sv
`timescale 1ns/100ps
`include "snake_lcd_defines.svh"

module rainbow_rand (
    input  logic             clk,
    input  logic             nrst,
    input  logic             enable,
    output lcd_pkg::rgb565_t rainbow_color
);

    lcd_pkg::rgb565_t lfsr;

    // Galois form, shifts right and folds the taps in on a one
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst)
            lfsr <= `RAINBOW_SEED;
        else if (enable)
            lfsr <= (lfsr >> 1) ^ ({16{lfsr[0]}} & `RAINBOW_TAPS);
    end

    assign rainbow_color = lfsr;    // Held between body cells

endmodule

// File: verilog/cell_board.sv
`timescale 1ns/100ps
`include "snake_lcd_defines.svh"

module cell_board (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   cell_we,
    input  board_pkg::cell_coord_t cell_x,
    input  board_pkg::cell_coord_t cell_y,
    input  board_pkg::obj_code_t   cell_code,
    input  logic                   draw_take,
    output logic                   draw_req,
    output board_pkg::cell_coord_t draw_x,
    output board_pkg::cell_coord_t draw_y,
    output board_pkg::obj_code_t   draw_code,
    output logic                   any_dirty
);

    localparam int CELLS   = `BOARD_COLS * `BOARD_ROWS;
    localparam int IDX_W   = $clog2(CELLS);
    localparam int COUNT_W = $clog2(CELLS + 1);

    localparam board_pkg::cell_coord_t LAST_COL = board_pkg::cell_coord_t'(`BOARD_COLS - 1);
    localparam board_pkg::cell_coord_t LAST_ROW = board_pkg::cell_coord_t'(`BOARD_ROWS - 1);

    board_pkg::obj_code_t   codes [CELLS];
    logic [CELLS-1:0]       dirty;
    logic [COUNT_W-1:0]     dirty_count;
    board_pkg::cell_coord_t scan_x, scan_y;
    logic [IDX_W-1:0]       wr_idx, scan_idx;
    logic                   wr_valid, set_dirty, clr_dirty;

    assign wr_valid = cell_we && (cell_x < `BOARD_COLS) && (cell_y < `BOARD_ROWS);
    assign wr_idx   = IDX_W'(cell_y * `BOARD_COLS + cell_x);
    assign scan_idx = IDX_W'(scan_y * `BOARD_COLS + scan_x);

    assign set_dirty = wr_valid && !dirty[wr_idx];
    assign clr_dirty = draw_take && !(wr_valid && (wr_idx == scan_idx));  // Same-cell write wins

    always_ff @(posedge clk) begin
        if (wr_valid)
            codes[wr_idx] <= cell_code;
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            dirty       <= '0;
            dirty_count <= '0;
        end else begin
            if (clr_dirty)
                dirty[scan_idx] <= 1'b0;
            if (wr_valid)
                dirty[wr_idx] <= 1'b1;
            dirty_count <= dirty_count + COUNT_W'(set_dirty) - COUNT_W'(clr_dirty);
        end
    end

    // Raster scan, parks on a dirty cell until it is taken
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            scan_x <= '0;
            scan_y <= '0;
        end else if (!draw_req) begin
            if (scan_x == LAST_COL) begin
                scan_x <= '0;
                if (scan_y == LAST_ROW)
                    scan_y <= '0;
                else
                    scan_y <= scan_y + 1'b1;
            end else begin
                scan_x <= scan_x + 1'b1;
            end
        end
    end

    assign draw_req  = dirty[scan_idx];
    assign draw_x    = scan_x;
    assign draw_y    = scan_y;
    assign draw_code = codes[scan_idx];
    assign any_dirty = (dirty_count != '0);

endmodule

// File: verilog/board_pkg.sv
package board_pkg;

    // One code per board cell as written by the game
    typedef enum logic [2:0] {
        OBJ_BLANK  = 3'd0,
        OBJ_HEAD   = 3'd1,
        OBJ_BODY   = 3'd2,
        OBJ_APPLE  = 3'd3,
        OBJ_BORDER = 3'd4
    } obj_code_t;

    typedef logic [3:0] cell_coord_t;    // Cell column or row

endpackage

// File: verilog/lcd_pkg.sv
package lcd_pkg;

    // SET steps advance the command table and SEND steps hold it
    typedef enum logic [2:0] {
        IDLE,
        SET_I,      // Start-up byte, strobe low
        SEND_I,     // Start-up byte, strobe high
        SET,        // Cell byte, strobe low
        SEND        // Cell byte, strobe high
    } update_t;

    typedef logic [7:0]  lcd_byte_t;     // One byte on the 8080 bus

    typedef logic [4:0]  cmd_idx_t;      // Step in the command table

    typedef logic [15:0] rgb565_t;

    typedef logic [16:0] pix_count_t;    // Pixel and pause counter

endpackage

// File: verilog/snake_lcd_defines.svh
`ifndef SNAKE_LCD_DEFINES_SVH
`define SNAKE_LCD_DEFINES_SVH

`define BOARD_COLS   16
`define BOARD_ROWS   12
`define CELL_PX      20             // Cell edge in pixels

`define INIT_PAUSE   64             // Cycles per start-up pause
`define CLEAR_PIXELS 32             // 76800 clears the full panel

`define COLOR_BLANK  16'h1408
`define COLOR_HEAD   16'h901E
`define COLOR_BORDER 16'h0000
`define COLOR_APPLE  16'hE7F9
`define COLOR_LEAF   16'hA071       // Top row of an apple

`define RAINBOW_SEED 16'hACE1
`define RAINBOW_TAPS 16'hB400

`endif
